// File: adpll_pkg.sv
package adpll_pkg;

   ////////////////////////////////////////////////////////////
   // Word widths
   ////////////////////////////////////////////////////////////

   // FCW is unsigned Q12.14
   localparam int FRAW = 14;
   localparam int INTW = 12;
   localparam int FCWW = INTW + FRAW;
   // One guard bit for the signed phase error
   localparam int ACCW = FCWW + 1;
   localparam int OTWW = ACCW - FRAW;

   typedef logic        [FCWW-1:0] fcw_t;
   typedef logic signed [ACCW-1:0] acc_t;
   typedef logic        [INTW-1:0] tdc_t;
   typedef logic signed [OTWW-1:0] otw_int_t;
   typedef logic signed [7:0]      bank_word_t;
   typedef logic signed [4:0]      large_word_t;
   typedef logic        [3:0]      shift_t;

   ////////////////////////////////////////////////////////////
   // Modes and bank states
   ////////////////////////////////////////////////////////////

   // Code 3 is unused and falls back to power-down
   typedef enum logic [1:0] {
      PD   = 2'd0,
      TEST = 2'd1,
      RX   = 2'd2
   } adpll_mode_t;

   typedef enum logic [4:0] {
      IDLE = 5'b00001,
      PU   = 5'b00010,
      C_L  = 5'b00100,
      C_M  = 5'b01000,
      C_S  = 5'b10000
   } bank_state_t;

   typedef struct packed {
      shift_t alpha_l;
      shift_t alpha_m;
      shift_t alpha_s;
      shift_t beta;
   } loop_gain_t;

   typedef struct packed {
      large_word_t c_l;
      bank_word_t  c_m;
      bank_word_t  c_s;
   } dco_words_t;

   typedef struct packed {
      logic dco_pd;
      logic tdc_pd;
      logic tdc_pd_inj;
   } power_t;

   // Capacitor bank ranges
   localparam int L_MAX  = 12;
   localparam int L_MIN  = -13;
   localparam int MS_MAX = 127;
   localparam int MS_MIN = -128;

   // Repeats of one word before a bank counts as settled
   localparam int LOCK_COUNT_COARSE = 8;
   localparam int LOCK_COUNT_FINE   = 15;

endpackage

// File: phase_accum.sv
`timescale 1ns/1ps

module phase_accum (
   input  logic             clk,
   input  logic             rst_accum_all,
   input  logic             en,
   input  logic             clear_loop,
   input  adpll_pkg::fcw_t  fcw,
   input  adpll_pkg::tdc_t  tdc_word,
   output adpll_pkg::acc_t  phase_acc
);

   adpll_pkg::acc_t fcw_ext;
   adpll_pkg::acc_t tdc_ext;
   adpll_pkg::acc_t phase_err;

   // TDC word is integer only, align it to the FCW fraction
   assign fcw_ext   = {1'b0, fcw};
   assign tdc_ext   = {1'b0, tdc_word, {adpll_pkg::FRAW{1'b0}}};
   assign phase_err = fcw_ext - tdc_ext;

   always_ff @(posedge clk) begin
      if (rst_accum_all) begin
         phase_acc <= '0;
      end else if (en) begin
         if (clear_loop) begin
            phase_acc <= '0;
         end else begin
            phase_acc <= phase_acc + phase_err;
         end
      end
   end

   // Each bank starts from a cleared phase
   a_clear_acc: assert property (
      @(posedge clk) disable iff (rst_accum_all)
      (en && clear_loop) |=> (phase_acc == '0)
   ) else $error("phase_acc not cleared after clear_loop");

endmodule

// File: loop_filter.sv
`timescale 1ns/1ps

module loop_filter #(
   parameter int OTW_SHIFT = 7
) (
   input  logic                    clk,
   input  logic                    rst_accum_all,
   input  logic                    en,
   input  logic                    clear_loop,
   input  adpll_pkg::acc_t         phase_acc,
   input  adpll_pkg::bank_state_t  state,
   input  adpll_pkg::loop_gain_t   gains,
   output adpll_pkg::otw_int_t     otw_round,
   output adpll_pkg::bank_word_t   otw_sat
);

   adpll_pkg::shift_t   alpha;
   logic                int_en;
   adpll_pkg::acc_t     integ_q;
   adpll_pkg::acc_t     integ_sum;
   adpll_pkg::acc_t     prop;
   adpll_pkg::acc_t     ntw;
   adpll_pkg::acc_t     otw;
   adpll_pkg::otw_int_t otw_int;

   function automatic adpll_pkg::bank_word_t clip(adpll_pkg::otw_int_t w, int lo, int hi);
      adpll_pkg::bank_word_t res;
      if (int'(w) > hi) begin
         res = adpll_pkg::bank_word_t'(hi);
      end else if (int'(w) < lo) begin
         res = adpll_pkg::bank_word_t'(lo);
      end else begin
         res = w[7:0];
      end
      return res;
   endfunction

   // Proportional gain follows the active bank
   always_comb begin
      case (state)
         adpll_pkg::C_L: alpha = gains.alpha_l;
         adpll_pkg::C_M: alpha = gains.alpha_m;
         default:        alpha = gains.alpha_s;
      endcase
   end

   // Integral path only on the small bank
   assign int_en    = (state == adpll_pkg::C_S) && (gains.beta != '0);
   assign integ_sum = integ_q + phase_acc;
   assign prop      = phase_acc >>> alpha;
   assign ntw       = int_en ? prop + (integ_sum >>> gains.beta) : prop;

   ////////////////////////////////////////////////////////////
   // Scaling, rounding and bank saturation
   ////////////////////////////////////////////////////////////

   assign otw       = ntw <<< OTW_SHIFT;
   assign otw_int   = otw[adpll_pkg::ACCW-1:adpll_pkg::FRAW];
   // Round half up on the top fraction bit
   assign otw_round = otw_int + adpll_pkg::otw_int_t'(otw[adpll_pkg::FRAW-1]);

   always_comb begin
      if (state == adpll_pkg::C_L) begin
         otw_sat = clip(otw_round, adpll_pkg::L_MIN, adpll_pkg::L_MAX);
      end else begin
         otw_sat = clip(otw_round, adpll_pkg::MS_MIN, adpll_pkg::MS_MAX);
      end
   end

   always_ff @(posedge clk) begin
      if (rst_accum_all) begin
         integ_q <= '0;
      end else if (en) begin
         if (clear_loop) begin
            integ_q <= '0;
         end else if (int_en) begin
            integ_q <= integ_sum;
         end
      end
   end

   a_large_range: assert property (
      @(posedge clk) disable iff (rst_accum_all)
      (state == adpll_pkg::C_L) |->
         (int'(otw_sat) >= adpll_pkg::L_MIN) && (int'(otw_sat) <= adpll_pkg::L_MAX)
   ) else $error("otw_sat outside large bank range");

endmodule

// File: lock_detector.sv
`timescale 1ns/1ps

module lock_detector (
   input  logic                    clk,
   input  logic                    rst_accum_all,
   input  logic                    en,
   input  logic                    lock_clear,
   input  logic                    lock_en,
   input  adpll_pkg::bank_state_t  state,
   input  adpll_pkg::bank_word_t   otw_sat,
   input  adpll_pkg::otw_int_t     otw_round,
   output logic                    lock,
   output adpll_pkg::bank_word_t   lock_word
);

   adpll_pkg::bank_word_t cand1;
   adpll_pkg::bank_word_t cand2;
   logic [4:0]            cnt1;
   logic [4:0]            cnt2;
   logic [4:0]            cnt1_inc;
   logic [4:0]            cnt2_inc;
   logic [4:0]            count_goal;
   logic                  railed;
   logic                  hit1;
   logic                  hit2;

   // Word pinned at a bank limit cannot settle any further
   assign railed = (otw_round != adpll_pkg::otw_int_t'(otw_sat));

   assign count_goal = (state == adpll_pkg::C_L || railed) ?
                       5'(adpll_pkg::LOCK_COUNT_COARSE) :
                       5'(adpll_pkg::LOCK_COUNT_FINE);

   // A zero count marks an empty candidate slot
   assign hit1     = (cnt1 != '0) && (otw_sat == cand1);
   assign hit2     = (cnt2 != '0) && (otw_sat == cand2);
   assign cnt1_inc = cnt1 + 5'd1;
   assign cnt2_inc = cnt2 + 5'd1;

   always_ff @(posedge clk) begin
      if (rst_accum_all) begin
         cnt1 <= '0;
         cnt2 <= '0;
         lock <= 1'b0;
      end else if (en) begin
         if (lock_clear) begin
            cnt1 <= '0;
            cnt2 <= '0;
            lock <= 1'b0;
         end else if (lock_en && !lock) begin
            if (hit1) begin
               cnt1 <= cnt1_inc;
               if (cnt1_inc >= count_goal) begin
                  lock      <= 1'b1;
                  lock_word <= cand1;
               end
            end else if (hit2) begin
               cnt2 <= cnt2_inc;
               if (cnt2_inc >= count_goal) begin
                  lock      <= 1'b1;
                  lock_word <= cand2;
               end
            end else begin
               // New word, the older candidate drops out
               cand1 <= otw_sat;
               cnt1  <= 5'd1;
               cand2 <= cand1;
               cnt2  <= cnt1;
            end
         end
      end
   end

   a_lock_needs_en: assert property (
      @(posedge clk) disable iff (rst_accum_all)
      $rose(lock) |-> $past(lock_en)
   ) else $error("lock rose while lock_en was low");

endmodule

// File: bank_sequencer.sv
`timescale 1ns/1ps

module bank_sequencer #(
   parameter int PU_TDC_CYCLES    = 16,
   parameter int PU_INJ_CYCLES    = 48,
   parameter int PU_DONE_CYCLES   = 112,
   parameter int LOCK_WAIT_CYCLES = 480
) (
   input  logic                    clk,
   input  logic                    rst_accum_all,
   input  logic                    en,
   input  adpll_pkg::adpll_mode_t  mode,
   input  adpll_pkg::fcw_t         fcw,
   input  adpll_pkg::bank_word_t   otw_sat,
   input  logic                    lock,
   input  adpll_pkg::bank_word_t   lock_word,
   output adpll_pkg::bank_state_t  state,
   output logic                    clear_loop,
   output logic                    lock_clear,
   output logic                    lock_en,
   output adpll_pkg::dco_words_t   bank_words,
   output adpll_pkg::power_t       power,
   output logic                    channel_lock
);

   adpll_pkg::bank_state_t state_nxt;
   logic [8:0]             timer;
   logic [8:0]             timer_nxt;
   adpll_pkg::power_t      power_nxt;
   adpll_pkg::dco_words_t  frozen;
   adpll_pkg::dco_words_t  frozen_nxt;
   adpll_pkg::fcw_t        fcw_last;
   adpll_pkg::adpll_mode_t mode_last;
   logic                   clear_loop_nxt;
   logic                   lock_clear_nxt;
   logic                   lock_en_nxt;
   logic                   channel_lock_nxt;
   logic                   restart;

   // Any new channel or mode starts the sequence over
   assign restart = (fcw != fcw_last) || (mode != mode_last);

   ////////////////////////////////////////////////////////////
   // Sequence FSM
   ////////////////////////////////////////////////////////////

   always_comb begin
      state_nxt        = state;
      timer_nxt        = timer;
      power_nxt        = power;
      frozen_nxt       = frozen;
      clear_loop_nxt   = 1'b0;
      lock_clear_nxt   = 1'b0;
      lock_en_nxt      = lock_en;
      channel_lock_nxt = channel_lock;

      if (restart) begin
         state_nxt        = adpll_pkg::IDLE;
         lock_en_nxt      = 1'b0;
         lock_clear_nxt   = 1'b1;
         channel_lock_nxt = 1'b0;
      end else begin
         case (state)
            adpll_pkg::IDLE: begin
               timer_nxt        = '0;
               frozen_nxt       = '0;
               lock_en_nxt      = 1'b0;
               lock_clear_nxt   = 1'b1;
               channel_lock_nxt = 1'b0;
               if (mode == adpll_pkg::RX) begin
                  state_nxt = adpll_pkg::PU;
               end else begin
                  power_nxt = '1;
               end
            end
            adpll_pkg::PU: begin
               // DCO first, TDC and injection follow on the timer
               timer_nxt        = timer + 9'd1;
               power_nxt.dco_pd = 1'b0;
               if (timer == 9'(PU_TDC_CYCLES)) begin
                  power_nxt.tdc_pd = 1'b0;
               end
               if (timer == 9'(PU_INJ_CYCLES)) begin
                  power_nxt.tdc_pd_inj = 1'b0;
               end
               if (timer == 9'(PU_DONE_CYCLES)) begin
                  state_nxt      = adpll_pkg::C_L;
                  timer_nxt      = '0;
                  clear_loop_nxt = 1'b1;
                  lock_clear_nxt = 1'b1;
               end
            end
            adpll_pkg::C_L: begin
               lock_en_nxt = 1'b1;
               // Lock is stale during the clear cycle
               if (lock && !clear_loop) begin
                  frozen_nxt.c_l = adpll_pkg::large_word_t'(lock_word[4:0]);
                  state_nxt      = adpll_pkg::C_M;
                  clear_loop_nxt = 1'b1;
                  lock_clear_nxt = 1'b1;
               end
            end
            adpll_pkg::C_M: begin
               if (lock && !clear_loop) begin
                  frozen_nxt.c_m = lock_word;
                  state_nxt      = adpll_pkg::C_S;
                  clear_loop_nxt = 1'b1;
                  lock_clear_nxt = 1'b1;
                  lock_en_nxt    = 1'b0;
               end
            end
            adpll_pkg::C_S: begin
               // Small bank keeps tracking, lock after a fixed wait
               if (!channel_lock) begin
                  timer_nxt = timer + 9'd1;
                  if (timer == 9'(LOCK_WAIT_CYCLES - 1)) begin
                     channel_lock_nxt = 1'b1;
                  end
               end
            end
            default: state_nxt = adpll_pkg::IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (rst_accum_all) begin
         state        <= adpll_pkg::IDLE;
         timer        <= '0;
         power        <= '1;
         frozen       <= '0;
         clear_loop   <= 1'b0;
         lock_clear   <= 1'b0;
         lock_en      <= 1'b0;
         channel_lock <= 1'b0;
         fcw_last     <= fcw;
         mode_last    <= mode;
      end else if (en) begin
         state        <= state_nxt;
         timer        <= timer_nxt;
         power        <= power_nxt;
         frozen       <= frozen_nxt;
         clear_loop   <= clear_loop_nxt;
         lock_clear   <= lock_clear_nxt;
         lock_en      <= lock_en_nxt;
         channel_lock <= channel_lock_nxt;
         fcw_last     <= fcw;
         mode_last    <= mode;
      end
   end

   // Active bank follows the filter, others show frozen words
   always_comb begin
      bank_words = frozen;
      if (!clear_loop) begin
         case (state)
            adpll_pkg::C_L: bank_words.c_l = adpll_pkg::large_word_t'(otw_sat[4:0]);
            adpll_pkg::C_M: bank_words.c_m = otw_sat;
            adpll_pkg::C_S: bank_words.c_s = otw_sat;
            default:        bank_words = frozen;
         endcase
      end
      if (state == adpll_pkg::IDLE) begin
         bank_words = '0;
      end
   end

   a_lock_in_cs: assert property (
      @(posedge clk) disable iff (rst_accum_all)
      channel_lock |-> (state == adpll_pkg::C_S)
   ) else $error("channel_lock high outside C_S");

endmodule

// File: adpll_ctrl.sv
`timescale 1ns/1ps

module adpll_ctrl #(
   parameter int PU_TDC_CYCLES    = 16,
   parameter int PU_INJ_CYCLES    = 48,
   parameter int PU_DONE_CYCLES   = 112,
   parameter int LOCK_WAIT_CYCLES = 480,
   parameter int OTW_SHIFT        = 7
) (
   input  logic                    clk,
   input  logic                    rst_accum_all,
   input  logic                    en,
   input  adpll_pkg::fcw_t         fcw,
   input  adpll_pkg::adpll_mode_t  mode,
   input  adpll_pkg::tdc_t         tdc_word,
   input  adpll_pkg::loop_gain_t   gains,
   input  adpll_pkg::dco_words_t   test_words,
   input  adpll_pkg::power_t       test_power,
   output adpll_pkg::dco_words_t   dco_words,
   output adpll_pkg::power_t       power,
   output logic                    channel_lock,
   output logic                    channel_sat
);

   adpll_pkg::acc_t        phase_acc;
   adpll_pkg::otw_int_t    otw_round;
   adpll_pkg::bank_word_t  otw_sat;
   adpll_pkg::bank_word_t  lock_word;
   adpll_pkg::bank_state_t state;
   adpll_pkg::dco_words_t  seq_words;
   adpll_pkg::power_t      seq_power;
   logic                   clear_loop;
   logic                   lock_clear;
   logic                   lock_en;
   logic                   lock;

   phase_accum phase_accum0 (
      .clk(clk), .rst_accum_all(rst_accum_all), .en(en), .clear_loop(clear_loop),
      .fcw(fcw), .tdc_word(tdc_word), .phase_acc(phase_acc)
   );

   loop_filter #(.OTW_SHIFT(OTW_SHIFT)) loop_filter0 (
      .clk(clk), .rst_accum_all(rst_accum_all), .en(en), .clear_loop(clear_loop),
      .phase_acc(phase_acc), .state(state), .gains(gains),
      .otw_round(otw_round), .otw_sat(otw_sat)
   );

   lock_detector lock_detector0 (
      .clk(clk), .rst_accum_all(rst_accum_all), .en(en),
      .lock_clear(lock_clear), .lock_en(lock_en), .state(state),
      .otw_sat(otw_sat), .otw_round(otw_round),
      .lock(lock), .lock_word(lock_word)
   );

   bank_sequencer #(
      .PU_TDC_CYCLES(PU_TDC_CYCLES), .PU_INJ_CYCLES(PU_INJ_CYCLES),
      .PU_DONE_CYCLES(PU_DONE_CYCLES), .LOCK_WAIT_CYCLES(LOCK_WAIT_CYCLES)
   ) bank_sequencer0 (
      .clk(clk), .rst_accum_all(rst_accum_all), .en(en),
      .mode(mode), .fcw(fcw), .otw_sat(otw_sat),
      .lock(lock), .lock_word(lock_word), .state(state),
      .clear_loop(clear_loop), .lock_clear(lock_clear), .lock_en(lock_en),
      .bank_words(seq_words), .power(seq_power), .channel_lock(channel_lock)
   );

   // TEST mode drives the analog side straight from the test inputs
   assign dco_words = (mode == adpll_pkg::TEST) ? test_words : seq_words;
   assign power     = (mode == adpll_pkg::TEST) ? test_power : seq_power;

   // Small bank at either rail, channel out of tuning range
   assign channel_sat = (int'(dco_words.c_s) == adpll_pkg::MS_MAX) ||
                        (int'(dco_words.c_s) == adpll_pkg::MS_MIN);

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
   parameter int PERIOD_NS    = 4,
   parameter int RESET_CYCLES = 3
) (
   output logic clk,
   output logic rst_accum_all
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2) clk = ~clk;
   end

   // Reset drops on a falling edge like every other input
   initial begin
      rst_accum_all = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      rst_accum_all = 1'b0;
   end

endmodule

// File: tb_adpll_ctrl.sv
`timescale 1ns/1ps

module tb_adpll_ctrl;

   localparam int PU_TDC_CYCLES   = 16;
   localparam int PU_INJ_CYCLES   = 48;
   localparam int CHANNEL_TIMEOUT = 2000;

   logic                   clk;
   logic                   rst_accum_all;
   logic                   en;
   adpll_pkg::fcw_t        fcw;
   adpll_pkg::adpll_mode_t mode;
   adpll_pkg::adpll_mode_t mode_d1;
   adpll_pkg::adpll_mode_t mode_d2;
   adpll_pkg::tdc_t        tdc_word;
   adpll_pkg::loop_gain_t  gains;
   adpll_pkg::dco_words_t  test_words;
   adpll_pkg::power_t      test_power;
   adpll_pkg::dco_words_t  dco_words;
   adpll_pkg::power_t      power;
   logic                   channel_lock;
   logic                   channel_sat;
   logic                   pd_held;
   integer                 seed;
   adpll_pkg::tdc_t        fcw_int;
   string                  test_name;

   tb_clock_gen #(.PERIOD_NS(4), .RESET_CYCLES(3)) clock_gen0 (
      .clk(clk), .rst_accum_all(rst_accum_all)
   );

   adpll_ctrl #(
      .PU_TDC_CYCLES(PU_TDC_CYCLES), .PU_INJ_CYCLES(PU_INJ_CYCLES),
      .PU_DONE_CYCLES(112), .LOCK_WAIT_CYCLES(480), .OTW_SHIFT(7)
   ) dut0 (
      .clk(clk), .rst_accum_all(rst_accum_all), .en(en), .fcw(fcw), .mode(mode),
      .tdc_word(tdc_word), .gains(gains), .test_words(test_words),
      .test_power(test_power), .dco_words(dco_words), .power(power),
      .channel_lock(channel_lock), .channel_sat(channel_sat)
   );

   ////////////////////////////////////////////////////////////
   // Error reporting
   ////////////////////////////////////////////////////////////

   task automatic abort_run(input string line);
      $display("%s", line);
      $display("*** TEST FAILED ***");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic report_mismatch(input string what, input int expected, input int actual);
      abort_run($sformatf("[ERROR] %s: %s expected %0d, actual %0d",
                          test_name, what, expected, actual));
   endtask

   task automatic check_value(input string what, input int expected, input int actual);
      if (expected != actual) begin
         report_mismatch(what, expected, actual);
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Assertions
   ////////////////////////////////////////////////////////////

   // Mode seen on the two previous edges
   always_ff @(posedge clk) begin
      mode_d1 <= mode;
      mode_d2 <= mode_d1;
   end

   assign pd_held = (mode == adpll_pkg::PD) && (mode_d1 == adpll_pkg::PD) &&
                    (mode_d2 == adpll_pkg::PD);

   a_pd_power: assert property (@(posedge clk) disable iff (rst_accum_all)
      pd_held |-> (power == 3'b111)
   ) else report_mismatch("power in PD", 7, int'($sampled(power)));

   a_pd_words: assert property (@(posedge clk) disable iff (rst_accum_all)
      pd_held |-> (dco_words == '0)
   ) else report_mismatch("dco_words in PD", 0, int'($sampled(dco_words)));

   a_pd_lock: assert property (@(posedge clk) disable iff (rst_accum_all)
      pd_held |-> !channel_lock
   ) else report_mismatch("channel_lock in PD", 0, int'($sampled(channel_lock)));

   a_test_words: assert property (@(posedge clk) disable iff (rst_accum_all)
      (mode == adpll_pkg::TEST) |-> (dco_words == test_words)
   ) else report_mismatch("dco_words in TEST", int'($sampled(test_words)),
                          int'($sampled(dco_words)));

   a_test_power: assert property (@(posedge clk) disable iff (rst_accum_all)
      (mode == adpll_pkg::TEST) |-> (power == test_power)
   ) else report_mismatch("power in TEST", int'($sampled(test_power)),
                          int'($sampled(power)));

   // Small word on either rail means saturation
   a_sat_rule: assert property (@(posedge clk) disable iff (rst_accum_all)
      channel_sat == ((int'(dco_words.c_s) == 127) || (int'(dco_words.c_s) == -128))
   ) else report_mismatch("channel_sat against c_s rail", int'(!$sampled(channel_sat)),
                          int'($sampled(channel_sat)));

   a_lock_rx: assert property (@(posedge clk) disable iff (rst_accum_all)
      channel_lock |-> (mode_d1 == adpll_pkg::RX)
   ) else report_mismatch("mode while locked", int'(adpll_pkg::RX), int'($sampled(mode_d1)));

   a_lock_powered: assert property (@(posedge clk) disable iff (rst_accum_all)
      (channel_lock && mode == adpll_pkg::RX) |-> (power == 3'b000)
   ) else report_mismatch("power while locked", 0, int'($sampled(power)));

   ////////////////////////////////////////////////////////////
   // Stimulus tasks run right after a falling edge
   ////////////////////////////////////////////////////////////

   function automatic adpll_pkg::tdc_t draw_fcw_int();
      logic [31:0] r;
      r = $random(seed);
      return adpll_pkg::tdc_t'(r % 32'd4094 + 32'd1);
   endfunction

   task automatic set_gains(input adpll_pkg::shift_t a_l, input adpll_pkg::shift_t a_m,
                            input adpll_pkg::shift_t a_s, input adpll_pkg::shift_t b);
      gains.alpha_l = a_l;
      gains.alpha_m = a_m;
      gains.alpha_s = a_s;
      gains.beta    = b;
   endtask

   task automatic wait_reset_release();
      int cyc;
      cyc = 0;
      while (rst_accum_all !== 1'b0 && cyc < 20) begin
         @(posedge clk);
         cyc++;
      end
      if (rst_accum_all !== 1'b0) begin
         abort_run("reset was never released");
      end
      @(negedge clk);
   endtask

   task automatic check_idle_outputs(input int cycles);
      int i;
      for (i = 0; i < cycles; i++) begin
         @(negedge clk);
         check_value("power", 7, int'(power));
         check_value("channel_lock", 0, int'(channel_lock));
         check_value("dco_words", 0, int'(dco_words));
         check_value("channel_sat", 0, int'(channel_sat));
      end
   endtask

   task automatic run_test_override();
      int                    i;
      logic [31:0]           r;
      adpll_pkg::dco_words_t tw;
      logic                  exp_sat;
      test_name = "test_override";
      mode = adpll_pkg::TEST;
      for (i = 0; i < 8; i++) begin
         r = $random(seed);
         tw.c_l = r[4:0];
         tw.c_m = r[12:5];
         case (i)
            0:       tw.c_s = 8'h7F;
            1:       tw.c_s = 8'h80;
            2:       tw.c_s = 8'h7E;
            3:       tw.c_s = 8'h81;
            default: tw.c_s = r[20:13];
         endcase
         test_words = tw;
         test_power = r[23:21];
         exp_sat = (int'(tw.c_s) == 127) || (int'(tw.c_s) == -128);
         @(negedge clk);
         check_value("dco_words", int'(test_words), int'(dco_words));
         check_value("power", int'(test_power), int'(power));
         check_value("channel_sat", int'(exp_sat), int'(channel_sat));
      end
   endtask

   // Power-up timing, bank search and final words of one RX channel
   task automatic run_channel(input string name, input adpll_pkg::tdc_t fcw_in,
                              input adpll_pkg::tdc_t tdc_in, input logic quiet,
                              input int exp_l, input int exp_m, input int exp_s,
                              input logic exp_sat);
      int cyc;
      int n_dco;
      int n_tdc;
      int n_inj;
      test_name = name;
      fcw       = {fcw_in, {adpll_pkg::FRAW{1'b0}}};
      tdc_word  = tdc_in;
      mode      = adpll_pkg::RX;
      cyc   = 0;
      n_dco = -1;
      n_tdc = -1;
      n_inj = -1;
      while (!channel_lock && cyc < CHANNEL_TIMEOUT) begin
         @(negedge clk);
         cyc++;
         if (n_dco < 0 && !power.dco_pd) begin
            n_dco = cyc;
         end
         if (n_tdc < 0 && !power.tdc_pd) begin
            n_tdc = cyc;
         end
         if (n_inj < 0 && !power.tdc_pd_inj) begin
            n_inj = cyc;
         end
         if (quiet) begin
            check_value("dco_words", 0, int'(dco_words));
            check_value("channel_sat", 0, int'(channel_sat));
         end
      end
      if (!channel_lock) begin
         abort_run($sformatf("%s: channel_lock did not rise within %0d cycles",
                             name, CHANNEL_TIMEOUT));
      end
      check_value("tdc_pd fall after dco_pd", PU_TDC_CYCLES, n_tdc - n_dco);
      check_value("tdc_pd_inj fall after dco_pd", PU_INJ_CYCLES, n_inj - n_dco);
      check_value("large word", exp_l, int'(dco_words.c_l));
      check_value("medium word", exp_m, int'(dco_words.c_m));
      check_value("small word", exp_s, int'(dco_words.c_s));
      check_value("channel_sat", int'(exp_sat), int'(channel_sat));
      for (cyc = 0; cyc < 4; cyc++) begin
         @(negedge clk);
         check_value("channel_lock held", 1, int'(channel_lock));
      end
   endtask

   task automatic return_to_pd(input string name);
      int cyc;
      test_name = name;
      mode = adpll_pkg::PD;
      cyc = 0;
      while (channel_lock && cyc < 2) begin
         @(negedge clk);
         cyc++;
      end
      if (channel_lock) begin
         abort_run($sformatf("%s: channel_lock still high 2 edges after PD", name));
      end
      cyc = 0;
      while (power != 3'b111 && cyc < 4) begin
         @(negedge clk);
         cyc++;
      end
      check_value("power after PD", 7, int'(power));
      check_idle_outputs(8);
   endtask

   ////////////////////////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////////////////////////

   initial begin
      seed       = 32'hb6be;
      en         = 1'b1;
      mode       = adpll_pkg::PD;
      fcw        = '0;
      tdc_word   = '0;
      gains      = '0;
      test_words = '0;
      test_power = 3'b111;
      test_name  = "reset";
      wait_reset_release();
      test_name = "reset_pd";
      check_idle_outputs(20);
      run_test_override();
      return_to_pd("test_to_pd");
      // Integral path on and still zero with no error
      set_gains(4'd7, 4'd4, 4'd7, 4'd4);
      fcw_int = draw_fcw_int();
      run_channel("zero_error", fcw_int, fcw_int, 1'b1, 0, 0, 0, 1'b0);
      return_to_pd("zero_to_pd");
      set_gains(4'd7, 4'd4, 4'd7, 4'd0);
      fcw_int = draw_fcw_int();
      run_channel("error_low", fcw_int, fcw_int - 12'd1, 1'b0, 12, 127, 127, 1'b1);
      return_to_pd("low_to_pd");
      fcw_int = draw_fcw_int();
      run_channel("error_high", fcw_int, fcw_int + 12'd1, 1'b0, -13, -128, -128, 1'b1);
      return_to_pd("mode_change");
      $display("*** TEST PASSED ***");
      $finish;
   end

endmodule

// File: all.f
adpll_pkg.sv
phase_accum.sv
loop_filter.sv
lock_detector.sv
bank_sequencer.sv
adpll_ctrl.sv
tb_clock_gen.sv
tb_adpll_ctrl.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the ADPLL control testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module tb_adpll_ctrl -f all.f
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

sim_out=$(./obj_dir/Vtb_adpll_ctrl 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if echo "$sim_out" | grep -qF '*** TEST PASSED ***'; then
   exit 0
fi
echo "pass message not found in simulation output"
exit 1
